//--- Makefile
# Verilator build and run for the start-up delay bank

VERILATOR ?= verilator
TOP       ?= enableDelayTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/enableDelayTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the start-up delay bank
// APB driver, reference model and cycle compare of delayedEnable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module enableDelayTb;
    import enableDelayPkg::*;

    localparam int CHANNEL_COUNT = 4;
    localparam int COUNTER_WIDTH = 16;
    // Five tests with delays of at most 40 cycles and a few dozen APB transfers
    // each fit in well under a thousand cycles, so this leaves ample margin
    localparam int CYCLE_LIMIT = 4000;

    logic                     clock;
    logic                     reset;
    apbRequest                apbIn;
    apbResponse               apbOut;
    logic [CHANNEL_COUNT-1:0] delayedEnable;
    logic                     interrupt;

    int          cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    logic        compareEnabled = 1'b0;
    logic [31:0] lcgState = 32'h6801;

    // Bench copy of the registers plus the edges at which each channel was
    // switched on and off, all in units of rising clock edges
    logic [CHANNEL_COUNT-1:0] shadowMask = '0;
    int shadowDelay [CHANNEL_COUNT];
    int modelDelay [CHANNEL_COUNT];
    int onEdge [CHANNEL_COUNT];
    int offEdge [CHANNEL_COUNT];

    enableDelayTop #(
        .CHANNEL_COUNT(CHANNEL_COUNT),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) enableDelayTop_inst (
        .clock        (clock),
        .reset        (reset),
        .apbIn        (apbIn),
        .apbOut       (apbOut),
        .delayedEnable(delayedEnable),
        .interrupt    (interrupt)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Counts rising edges, so after edge n the value is n
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // LCG step, scaled to a delay between 0 and 40
    function automatic int randomDelay();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]) % 41;
    endfunction

    function automatic logic [7:0] delayAddress(input int channel);
        return DELAY_BASE_ADDRESS + 8'(4 * channel);
    endfunction

    // Expected output word after a given edge
    // A channel switched on by a write ending at edge w rises at w+D+2
    // and a release ending at edge w takes it down at w+2
    function automatic logic [CHANNEL_COUNT-1:0] expectedOutputs(input int cycle);
        logic [CHANNEL_COUNT-1:0] word;
        word = '0;
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            if (onEdge[i] >= 0 && cycle >= onEdge[i] + modelDelay[i] + 2
                && (offEdge[i] < onEdge[i] || cycle < offEdge[i] + 2)) begin
                word[i] = 1'b1;
            end
        end
        return word;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s is 0x%h, expected 0x%h at cycle %0d",
                     name, actual, expected, cycleCount);
        end
    endtask

    // One APB transfer with setup and access phases, back to idle afterwards
    task automatic apbTransfer(input logic write, input logic [7:0] address,
                               input logic [31:0] data, output logic [31:0] readData,
                               output logic slaveError, output int endEdge);
        @(posedge clock);
        #1;
        apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: address, pwdata: data};
        @(posedge clock);
        #1;
        apbIn.penable = 1'b1;
        // Response is combinational in the access phase, sample mid cycle
        #2;
        readData   = apbOut.prdata;
        slaveError = apbOut.pslverr;
        // The slave has no wait states, so every access phase completes
        checkValue("pready", 32'(apbOut.pready), 32'h1);
        @(posedge clock);
        #1;
        endEdge = cycleCount;
        apbIn   = '0;
    endtask

    task automatic apbWrite(input logic [7:0] address, input logic [31:0] data,
                            input logic expectError);
        logic [31:0] readData;
        logic        slaveError;
        int          endEdge;
        apbTransfer(1'b1, address, data, readData, slaveError, endEdge);
        checkValue("pslverr", 32'(slaveError), 32'(expectError));
        if (!expectError && address == CONTROL_ADDRESS) begin
            // Delay is taken as the register held while the channel was off
            for (int i = 0; i < CHANNEL_COUNT; i++) begin
                if (data[i] && !shadowMask[i]) begin
                    onEdge[i]     = endEdge;
                    modelDelay[i] = shadowDelay[i];
                end else if (!data[i] && shadowMask[i]) begin
                    offEdge[i] = endEdge;
                end
            end
            shadowMask = data[CHANNEL_COUNT-1:0];
        end else if (!expectError && address >= DELAY_BASE_ADDRESS) begin
            shadowDelay[int'(address - DELAY_BASE_ADDRESS) / 4] = int'(data[COUNTER_WIDTH-1:0]);
        end
    endtask

    task automatic apbRead(input logic [7:0] address, input logic [31:0] expected,
                           input logic expectError);
        logic [31:0] readData;
        logic        slaveError;
        int          endEdge;
        apbTransfer(1'b0, address, 32'h0, readData, slaveError, endEdge);
        checkValue("pslverr", 32'(slaveError), 32'(expectError));
        if (!expectError) begin
            checkValue("prdata", readData, expected);
        end
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clock);
        #1;
    endtask

    // Polls once per cycle, the cycle limit guards against a stuck output
    task automatic waitForOutputs(input logic [CHANNEL_COUNT-1:0] value);
        do begin
            @(posedge clock);
            #1;
        end while (delayedEnable !== value);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("Test %s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    // Compare process, half a cycle after each edge where outputs are settled
    always @(negedge clock) begin
        if (compareEnabled) begin
            checkValue("delayedEnable", 32'(delayedEnable), 32'(expectedOutputs(cycleCount)));
        end
    end

    initial begin
        wait (cycleCount >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int errorsBefore;
        apbIn = '0;
        reset = 1'b0;
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            shadowDelay[i] = 0;
            modelDelay[i]  = 0;
            onEdge[i]      = -1;
            offEdge[i]     = -1;
        end
        repeat (10) @(posedge clock);
        #1;
        reset          = 1'b1;
        compareEnabled = 1'b1;

        // Random delays read back, then an unmapped access that must not land
        errorsBefore = errorCount;
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            apbWrite(delayAddress(i), 32'(randomDelay()), 1'b0);
        end
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            apbRead(delayAddress(i), 32'(shadowDelay[i]), 1'b0);
        end
        apbRead(CONTROL_ADDRESS, 32'h0, 1'b0);
        apbWrite(8'h40, 32'hFFFF_FFFF, 1'b1);
        apbRead(8'h40, 32'h0, 1'b1);
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            apbRead(delayAddress(i), 32'(shadowDelay[i]), 1'b0);
        end
        apbRead(CONTROL_ADDRESS, 32'h0, 1'b0);
        reportTest("1 register access", errorsBefore);

        // All channels from one write, each edge checked by the compare process
        errorsBefore = errorCount;
        apbWrite(CONTROL_ADDRESS, 32'hF, 1'b0);
        waitForOutputs(4'hF);
        waitCycles(2);
        reportTest("2 staggered start", errorsBefore);

        errorsBefore = errorCount;
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        apbWrite(delayAddress(1), 32'h0, 1'b0);
        apbWrite(CONTROL_ADDRESS, 32'h2, 1'b0);
        waitForOutputs(4'h2);
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        waitCycles(2);
        reportTest("3 zero delay and release", errorsBefore);

        // New delay written mid run only counts after an off period
        errorsBefore = errorCount;
        apbWrite(delayAddress(0), 32'd30, 1'b0);
        apbWrite(CONTROL_ADDRESS, 32'h1, 1'b0);
        waitCycles(5);
        apbWrite(delayAddress(0), 32'd5, 1'b0);
        waitForOutputs(4'h1);
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        apbWrite(CONTROL_ADDRESS, 32'h1, 1'b0);
        waitForOutputs(4'h1);
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        reportTest("4 delay latching", errorsBefore);

        errorsBefore = errorCount;
        apbWrite(STATUS_ADDRESS, 32'hF, 1'b0);
        apbWrite(delayAddress(0), 32'd3, 1'b0);
        apbWrite(delayAddress(2), 32'd7, 1'b0);
        apbWrite(CONTROL_ADDRESS, 32'h5, 1'b0);
        waitForOutputs(4'h5);
        apbRead(STATUS_ADDRESS, 32'h5, 1'b0);
        checkValue("interrupt", 32'(interrupt), 32'h1);
        apbWrite(STATUS_ADDRESS, 32'h1, 1'b0);
        // Clear pulse, start bit and interrupt each take one edge
        waitCycles(3);
        checkValue("interrupt", 32'(interrupt), 32'h0);
        apbRead(STATUS_ADDRESS, 32'h4, 1'b0);
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        apbWrite(delayAddress(3), 32'd40, 1'b0);
        apbWrite(CONTROL_ADDRESS, 32'h8, 1'b0);
        apbRead(STATUS_ADDRESS, 32'h8000_0004, 1'b0);
        waitForOutputs(4'h8);
        apbWrite(CONTROL_ADDRESS, 32'h0, 1'b0);
        waitForOutputs(4'h0);
        reportTest("5 status and interrupt", errorsBefore);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- bench/enableDelay_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Delay bank protocol checker
// APB error timing, interrupt masking and channel release
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module enableDelayChecker #(
    parameter int CHANNEL_COUNT = 4
) (
    input logic                       clock,
    input logic                       reset,
    input enableDelayPkg::apbRequest  apbIn,
    input enableDelayPkg::apbResponse apbOut,
    input logic [CHANNEL_COUNT-1:0]   channelEnable,
    input logic [CHANNEL_COUNT-1:0]   delayedEnable,
    input logic                       interrupt
);
    import enableDelayPkg::*;

    logic accessPhase;
    logic mappedAddress;

    assign accessPhase = apbIn.psel && apbIn.penable;

    // Control, status or one of the word aligned delay slots of the bank
    assign mappedAddress = (apbIn.paddr == CONTROL_ADDRESS)
                        || (apbIn.paddr == STATUS_ADDRESS)
                        || ((apbIn.paddr >= DELAY_BASE_ADDRESS)
                            && (apbIn.paddr < DELAY_BASE_ADDRESS + 8'(4 * CHANNEL_COUNT))
                            && (apbIn.paddr[1:0] == 2'b00));

    // The slave flags an unmapped address in the access phase and nowhere else
    errorInAccessOnly: assert property (@(posedge clock) disable iff (!reset)
        apbOut.pslverr == (accessPhase && !mappedAddress))
        else $error("pslverr does not match an unmapped access phase");

    // Interrupt is registered, so an empty mask shows one edge later
    noInterruptWithoutMask: assert property (@(posedge clock) disable iff (!reset)
        (channelEnable == '0) |=> !interrupt)
        else $error("interrupt high with an empty enable mask");

    // The channel registers its enable first, then drops active one edge later
    for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : releaseCheck
        outputFollowsRelease: assert property (@(posedge clock) disable iff (!reset)
            $fell(channelEnable[i]) |-> ##2 !delayedEnable[i])
            else $error("delayedEnable bit %0d still high after its enable fell", i);
    end

endmodule

bind enableDelayTop enableDelayChecker #(
    .CHANNEL_COUNT(CHANNEL_COUNT)
) enableDelayChecker_inst (
    .clock        (clock),
    .reset        (reset),
    .apbIn        (apbIn),
    .apbOut       (apbOut),
    .channelEnable(channelEnable),
    .delayedEnable(delayedEnable),
    .interrupt    (interrupt)
);

//--- compile.f
logic/enableDelayPkg.sv
logic/delayRegisterFile.sv
logic/enableDelayChannel.sv
logic/startStatusCollector.sv
logic/enableDelayTop.sv
bench/enableDelay_checker.sv
bench/enableDelayTb.sv

//--- logic/delayRegisterFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register file for the start-up delay bank
// Holds the enable mask and channel delays and pulses the status clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module delayRegisterFile #(
    parameter int CHANNEL_COUNT = 4,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    input  enableDelayPkg::apbRequest  apbIn,
    output enableDelayPkg::apbResponse apbOut,
    input  logic [CHANNEL_COUNT-1:0]   startedBits,
    input  logic                       busy,
    output logic [CHANNEL_COUNT-1:0]   channelEnable,
    output logic [COUNTER_WIDTH-1:0]   channelDelay [CHANNEL_COUNT],
    output logic [CHANNEL_COUNT-1:0]   statusClear
);
    import enableDelayPkg::*;

    logic        accessPhase;
    logic        writeAccess;
    logic        controlHit;
    logic        statusHit;
    logic        delayHit;
    logic        addressMapped;
    logic [7:0]  delayOffset;
    logic [5:0]  delayIndex;
    logic [31:0] readData;

    // The transfer completes in the access phase because pready is tied high
    assign accessPhase = apbIn.psel && apbIn.penable;
    assign writeAccess = accessPhase && apbIn.pwrite;

    // Address decode
    // The delay window starts at the base and holds one word per channel
    assign controlHit  = (apbIn.paddr == CONTROL_ADDRESS);
    assign statusHit   = (apbIn.paddr == STATUS_ADDRESS);
    assign delayOffset = apbIn.paddr - DELAY_BASE_ADDRESS;
    assign delayIndex  = delayOffset[7:2];

    // Unaligned addresses inside the window are treated as unmapped
    assign delayHit = (apbIn.paddr >= DELAY_BASE_ADDRESS)
                   && (delayOffset[1:0] == 2'b00)
                   && (int'(delayIndex) < CHANNEL_COUNT);

    assign addressMapped = controlHit || statusHit || delayHit;

    // Read mux, every register is zero extended to the bus width
    always_comb begin
        readData = '0;
        if (controlHit) begin
            readData[CHANNEL_COUNT-1:0] = channelEnable;
        end else if (statusHit) begin
            readData[CHANNEL_COUNT-1:0] = startedBits;
            // Busy lives in the top bit so the start bits can grow to 16
            readData[31] = busy;
        end else if (delayHit) begin
            for (int i = 0; i < CHANNEL_COUNT; i++) begin
                if (delayIndex == 6'(i)) begin
                    readData[COUNTER_WIDTH-1:0] = channelDelay[i];
                end
            end
        end
    end

    // Read data is only presented while the access phase is on the bus
    assign apbOut.prdata  = accessPhase ? readData : '0;
    assign apbOut.pready  = 1'b1;
    assign apbOut.pslverr = accessPhase && !addressMapped;

    // Control and delay registers
    // A write lands on the edge that closes the access phase
    always_ff @(posedge clock) begin
        if (!reset) begin
            channelEnable <= '0;
            for (int i = 0; i < CHANNEL_COUNT; i++) begin
                channelDelay[i] <= '0;
            end
        end else if (writeAccess) begin
            if (controlHit) begin
                channelEnable <= apbIn.pwdata[CHANNEL_COUNT-1:0];
            end
            // Each delay word only responds to its own slot in the window
            for (int i = 0; i < CHANNEL_COUNT; i++) begin
                if (delayHit && delayIndex == 6'(i)) begin
                    channelDelay[i] <= apbIn.pwdata[COUNTER_WIDTH-1:0];
                end
            end
        end
    end

    // A STATUS write becomes a one cycle clear pulse for the collector
    // The pulse carries the written low bits, so only the ones clear
    always_ff @(posedge clock) begin
        if (!reset) begin
            statusClear <= '0;
        end else if (writeAccess && statusHit) begin
            statusClear <= apbIn.pwdata[CHANNEL_COUNT-1:0];
        end else begin
            statusClear <= '0;
        end
    end

endmodule

//--- logic/enableDelayChannel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single start-up delay channel
// Raises active a latched number of cycles after enable rises
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module enableDelayChannel #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable,
    input  logic [COUNTER_WIDTH-1:0]    delay,
    output enableDelayPkg::channelState state
);

    logic                     enableSampled;
    logic [COUNTER_WIDTH-1:0] latchedDelay;
    logic [COUNTER_WIDTH-1:0] count;
    logic                     startCount;

    // First enabled cycle with a nonzero delay
    // Neither flag is set yet, so the countdown has not been loaded
    assign startCount = enableSampled
                     && !state.active
                     && !state.counting
                     && (latchedDelay != '0);

    // Enable sample and delay latch
    // The delay follows the register while the channel is off and freezes
    // at the edge that first sees enable high, so a rewrite during a run
    // only takes effect after the next off period
    always_ff @(posedge clock) begin
        if (!reset) begin
            enableSampled <= 1'b0;
            latchedDelay  <= '0;
        end else begin
            enableSampled <= enable;
            if (!enable) begin
                latchedDelay <= delay;
            end
        end
    end

    // Countdown and output state
    // Everything here runs one edge behind the enable sample, which gives
    // active at k+D+1 when enable is first sampled high at edge k
    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            state <= '0;
        end else if (!enableSampled) begin
            // Release drops both flags on the edge after enable is seen low
            count <= '0;
            state <= '0;
        end else if (latchedDelay == '0) begin
            // Zero delay skips the counter entirely
            state.active   <= 1'b1;
            state.counting <= 1'b0;
        end else if (startCount) begin
            count          <= latchedDelay;
            state.counting <= 1'b1;
        end else if (state.counting) begin
            if (count == COUNTER_WIDTH'(1)) begin
                // Last counted cycle, hand over from counting to active
                state.active   <= 1'b1;
                state.counting <= 1'b0;
            end
            count <= count - 1'b1;
        end
    end

endmodule

//--- logic/enableDelayPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Enable delay bank definitions
// APB bus structs, channel state and the register address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package enableDelayPkg;

    // Request side of the APB bus as driven by the master
    // The whole transfer is carried in one bundle so that the top level
    // and the register file see the same field order
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbRequest;

    // Response side of the APB bus
    // The slave never inserts wait states, so pready stays high
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbResponse;

    // Per-channel status as seen by the collector
    // active is the delayed enable itself
    // counting is high while the countdown toward active is running
    typedef struct packed {
        logic active;
        logic counting;
    } channelState;

    // Register map, all registers are word aligned

    // Enable mask, one bit per channel
    localparam logic [7:0] CONTROL_ADDRESS = 8'h00;

    // Sticky start bits in the low bits, busy flag in bit 31
    // Writing a one to a start bit clears it
    localparam logic [7:0] STATUS_ADDRESS = 8'h04;

    // First delay register
    // Channel i sits at this base plus four times i
    localparam logic [7:0] DELAY_BASE_ADDRESS = 8'h08;

endpackage

//--- logic/enableDelayTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start-up delay bank top level
// Register file, channel array and status collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module enableDelayTop #(
    parameter int CHANNEL_COUNT = 4,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    input  enableDelayPkg::apbRequest  apbIn,
    output enableDelayPkg::apbResponse apbOut,
    output logic [CHANNEL_COUNT-1:0]   delayedEnable,
    output logic                       interrupt
);
    import enableDelayPkg::*;

    // Register file outputs
    logic [CHANNEL_COUNT-1:0] channelEnable;
    logic [COUNTER_WIDTH-1:0] channelDelay [CHANNEL_COUNT];
    logic [CHANNEL_COUNT-1:0] statusClear;

    // Collector results read back over APB
    logic [CHANNEL_COUNT-1:0] startedBits;
    logic                     busy;

    // One state word per channel
    channelState channelStates [CHANNEL_COUNT];

    delayRegisterFile #(
        .CHANNEL_COUNT(CHANNEL_COUNT),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) delayRegisterFile_inst (
        .clock        (clock),
        .reset        (reset),
        .apbIn        (apbIn),
        .apbOut       (apbOut),
        .startedBits  (startedBits),
        .busy         (busy),
        .channelEnable(channelEnable),
        .channelDelay (channelDelay),
        .statusClear  (statusClear)
    );

    // Identical channels, each fed by its own enable bit and delay word
    for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : channelSlice
        enableDelayChannel #(
            .COUNTER_WIDTH(COUNTER_WIDTH)
        ) enableDelayChannel_inst (
            .clock (clock),
            .reset (reset),
            .enable(channelEnable[i]),
            .delay (channelDelay[i]),
            .state (channelStates[i])
        );
    end

    // The enable register doubles as the interrupt mask
    startStatusCollector #(
        .CHANNEL_COUNT(CHANNEL_COUNT)
    ) startStatusCollector_inst (
        .clock        (clock),
        .reset        (reset),
        .state        (channelStates),
        .enableMask   (channelEnable),
        .statusClear  (statusClear),
        .startedBits  (startedBits),
        .busy         (busy),
        .delayedEnable(delayedEnable),
        .interrupt    (interrupt)
    );

endmodule

//--- logic/startStatusCollector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start status collector
// Gathers channel outputs, sticky start bits and the interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module startStatusCollector #(
    parameter int CHANNEL_COUNT = 4
) (
    input  logic                        clock,
    input  logic                        reset,
    input  enableDelayPkg::channelState state [CHANNEL_COUNT],
    input  logic [CHANNEL_COUNT-1:0]    enableMask,
    input  logic [CHANNEL_COUNT-1:0]    statusClear,
    output logic [CHANNEL_COUNT-1:0]    startedBits,
    output logic                        busy,
    output logic [CHANNEL_COUNT-1:0]    delayedEnable,
    output logic                        interrupt
);

    logic [CHANNEL_COUNT-1:0] activeBits;
    logic [CHANNEL_COUNT-1:0] countingBits;
    logic [CHANNEL_COUNT-1:0] activePrevious;
    logic [CHANNEL_COUNT-1:0] activeRise;
    logic                     allStarted;

    // Split the channel states into two flat vectors
    always_comb begin
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
            activeBits[i]   = state[i].active;
            countingBits[i] = state[i].counting;
        end
    end

    // The output bus is the active bits with no extra stage
    assign delayedEnable = activeBits;

    // Any running countdown marks the bank as busy
    assign busy = |countingBits;

    // Rising edge of each active bit, against last cycle's copy
    assign activeRise = activeBits & ~activePrevious;

    // Every masked channel has started and the mask is not empty
    assign allStarted = (enableMask != '0)
                     && ((startedBits & enableMask) == enableMask);

    // Sticky start bits with write one to clear
    // The rise term is ORed in last, so a set wins over a clear
    always_ff @(posedge clock) begin
        if (!reset) begin
            activePrevious <= '0;
            startedBits    <= '0;
        end else begin
            activePrevious <= activeBits;
            startedBits    <= (startedBits & ~statusClear) | activeRise;
        end
    end

    // Registered interrupt, one edge after the start bits complete the mask
    always_ff @(posedge clock) begin
        if (!reset) begin
            interrupt <= 1'b0;
        end else begin
            interrupt <= allStarted;
        end
    end

endmodule
